// File: verilog.f
+incdir+.
frame_pkg.sv
stream_pkg.sv
fifo_if.sv
sync_fifo.sv
frame_header_builder.sv
async_dataframe_gen.sv
dataframe_top.sv
tb_dataframe_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dataframe_top -f verilog.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_dataframe_top.sv
`include "dataframe_consts.svh"

module tb_dataframe_top;

    import frame_pkg::*;
    import stream_pkg::*;

    localparam int WAIT_LIMIT = 5000;
    localparam int NO_LIMIT   = 1 << 12;

    typedef struct packed {
        logic  last;
        keep_t keep;
        beat_t data;
    } exp_beat_t;

    logic       ACLK;
    logic       ARESET;
    logic       frame_start;
    frame_len_t frame_len;
    ch_id_t     ch_id;
    logic       adc_valid;
    beat_t      adc_data;
    logic       busy;
    logic       m_axis_tready;
    logic       m_axis_tvalid;
    beat_t      m_axis_tdata;
    keep_t      m_axis_tkeep;
    logic       m_axis_tlast;
    logic       overflow_error;
    logic       underrun_error;

    exp_beat_t  exp_q[$];
    df_word_t   tb_ts;      // runs in step with the builder timestamp
    df_word_t   seq_num;
    logic [1:0] bp_mode;    // 0 always ready, 1 random, 2 held low
    int         value_errs;
    int         other_errs;
    string      test_name;
    logic       hold_pend;
    beat_t      hold_data;
    keep_t      hold_keep;
    logic       hold_last;

    dataframe_top dut0 (.*);

    initial begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;
    end

    always @(posedge ACLK) begin
        if (ARESET) begin
            tb_ts <= '0;
        end else begin
            tb_ts <= tb_ts + 32'd1;
        end
    end

    always @(posedge ACLK) begin
        case (bp_mode)
            2'd0: m_axis_tready <= 1'b1;
            2'd1: m_axis_tready <= ($urandom_range(0, 1) == 1);
            default: m_axis_tready <= 1'b0;
        endcase
    end

    task automatic report_value(input string what, input logic [63:0] expv,
                                input logic [63:0] actv);
        value_errs++;
        $display("FAIL %s %s expected %h actual %h", test_name, what, expv, actv);
    endtask

    function automatic void expect_beat(beat_t data, keep_t keep, logic last);
        exp_beat_t e;
        e.data = data;
        e.keep = keep;
        e.last = last;
        exp_q.push_back(e);
    endfunction

    always @(posedge ACLK) begin : monitor
        exp_beat_t e;
        if (!ARESET && m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("output beat %h arrived when no beat was expected", m_axis_tdata);
            end else begin
                e = exp_q.pop_front();
                assert (m_axis_tdata == e.data) else report_value("tdata", e.data, m_axis_tdata);
                assert (m_axis_tkeep == e.keep) else report_value("tkeep", e.keep, m_axis_tkeep);
                assert (m_axis_tlast == e.last) else report_value("tlast", e.last, m_axis_tlast);
            end
        end
    end

    // a stalled beat must hold until it transfers
    always @(posedge ACLK) begin
        if (!ARESET && hold_pend) begin
            assert (m_axis_tvalid) else report_value("hold tvalid", 1, m_axis_tvalid);
            assert (m_axis_tdata == hold_data) else report_value("hold tdata", hold_data,
                                                                  m_axis_tdata);
            assert (m_axis_tkeep == hold_keep) else report_value("hold tkeep", hold_keep,
                                                                  m_axis_tkeep);
            assert (m_axis_tlast == hold_last) else report_value("hold tlast", hold_last,
                                                                  m_axis_tlast);
        end
        hold_pend <= !ARESET && m_axis_tvalid && !m_axis_tready;
        hold_data <= m_axis_tdata;
        hold_keep <= m_axis_tkeep;
        hold_last <= m_axis_tlast;
    end

    assert property (@(posedge ACLK) disable iff (ARESET) !underrun_error)
        else report_value("underrun_error", 0, 1);

    task automatic wait_ready(input int backlog);
        int t;
        t = 0;
        do begin
            @(posedge ACLK);
            t++;
        end while ((busy || exp_q.size() > backlog) && t < WAIT_LIMIT);
        if (busy || exp_q.size() > backlog) begin
            other_errs++;
            $display("timed out waiting for the builder to go idle and the output to drain");
        end
    endtask

    task automatic run_frame(input int len, input int room, input bit noise,
                             input int backlog);
        ch_id_t   ch;
        df_word_t xor_lo;
        df_word_t xor_hi;
        beat_t    smp;
        int       n;
        int       k;
        int       stored;
        wait_ready(backlog);
        ch = ch_id_t'($urandom);
        if (noise) begin
            adc_valid <= 1'b1; // stray beat while the builder is idle
            adc_data  <= {$urandom, $urandom};
            @(posedge ACLK);
            adc_valid <= 1'b0;
        end
        frame_start <= 1'b1;
        frame_len   <= frame_len_t'(len);
        ch_id       <= ch;
        @(posedge ACLK);
        // builder latches its timestamp on this edge
        expect_beat({seq_num, `HEADER_ID, ch, frame_len_t'(len), 8'h00}, '1, 1'b0);
        expect_beat({`DF_MAGIC, tb_ts}, '1, 1'b0);
        n = 0;
        k = 0;
        stored = 0;
        xor_lo = '0;
        xor_hi = '0;
        while (n < len) begin
            frame_start <= noise && (k == 0);          // request while busy
            ch_id       <= (noise && (k == 0)) ? ~ch : ch;
            if ($urandom_range(0, 3) != 0) begin
                smp = {$urandom, $urandom};
                adc_valid <= 1'b1;
                adc_data  <= smp;
                if (stored < room) begin
                    expect_beat(smp, '1, 1'b0);
                    xor_lo ^= smp[31:0];
                    xor_hi ^= smp[63:32];
                    stored++;
                end
                n++;
            end else begin
                adc_valid <= 1'b0;
            end
            k++;
            @(posedge ACLK);
        end
        frame_start <= 1'b0;
        adc_valid   <= 1'b0;
        expect_beat({xor_hi, xor_lo}, '1, 1'b0);
        expect_beat({32'hFFFF_FFFF, df_word_t'(stored)}, 8'h0F, 1'b1);
        seq_num++;
    endtask

    task automatic zero_length_request();
        wait_ready(NO_LIMIT);
        frame_start <= 1'b1;
        frame_len   <= '0;
        @(posedge ACLK);
        frame_start <= 1'b0;
        @(posedge ACLK);
        assert (!busy) else report_value("zero length busy", 0, busy);
    endtask

    initial begin
        void'($urandom(31));
        ARESET        = 1'b1;
        frame_start   = 1'b0;
        frame_len     = '0;
        ch_id         = '0;
        adc_valid     = 1'b0;
        adc_data      = '0;
        m_axis_tready = 1'b0;
        bp_mode       = 2'd0;
        hold_pend     = 1'b0;
        seq_num       = '0;
        value_errs    = 0;
        other_errs    = 0;
        test_name     = "reset";
        repeat (2) @(posedge ACLK);
        ARESET <= 1'b0;
        @(posedge ACLK);
        assert (!m_axis_tvalid && !m_axis_tlast)
            else report_value("tvalid tlast", 0, {m_axis_tvalid, m_axis_tlast});
        assert (!overflow_error && !busy)
            else report_value("overflow busy", 0, {overflow_error, busy});

        test_name = "content";
        repeat (8) run_frame($urandom_range(1, 20), NO_LIMIT, 1'b0, 15);

        test_name = "backpressure";
        bp_mode <= 2'd1;
        repeat (8) run_frame($urandom_range(1, 20), NO_LIMIT, 1'b0, 15);

        test_name = "ignored_input";
        zero_length_request();
        repeat (4) run_frame($urandom_range(1, 20), NO_LIMIT, 1'b1, 15);

        test_name = "overflow";
        wait_ready(0);
        assert (!overflow_error) else report_value("overflow_error early", 0, 1);
        bp_mode <= 2'd2;
        run_frame(`ADC_FIFO_DEPTH + 6, `ADC_FIFO_DEPTH, 1'b0, NO_LIMIT);
        @(posedge ACLK);
        assert (overflow_error) else report_value("overflow_error", 1, 0);
        bp_mode <= 2'd1;
        wait_ready(0);

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dataframe_top.sv
`include "dataframe_consts.svh"

module dataframe_top (
    input  logic                  ACLK,
    input  logic                  ARESET,
    input  logic                  frame_start,
    input  frame_pkg::frame_len_t frame_len,
    input  frame_pkg::ch_id_t     ch_id,
    input  logic                  adc_valid,
    input  stream_pkg::beat_t     adc_data,
    output logic                  busy,
    input  logic                  m_axis_tready,
    output logic                  m_axis_tvalid,
    output stream_pkg::beat_t     m_axis_tdata,
    output stream_pkg::keep_t     m_axis_tkeep,
    output logic                  m_axis_tlast,
    output logic                  overflow_error,
    output logic                  underrun_error
);

    import frame_pkg::*;
    import stream_pkg::*;

    fifo_if #(.WIDTH($bits(beat_t)))     adc_q ();
    fifo_if #(.WIDTH($bits(hf_entry_t))) hf_q ();

    frame_header_builder u_builder (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .frame_start    (frame_start),
        .frame_len      (frame_len),
        .ch_id          (ch_id),
        .adc_valid      (adc_valid),
        .adc_data       (adc_data),
        .adc_q          (adc_q),
        .hf_q           (hf_q),
        .overflow_error (overflow_error),
        .busy           (busy)
    );

    // samples of the frames waiting to be streamed
    sync_fifo #(
        .WIDTH ($bits(beat_t)),
        .DEPTH (`ADC_FIFO_DEPTH)
    ) u_adc_fifo (
        .ACLK   (ACLK),
        .ARESET (ARESET),
        .q      (adc_q)
    );

    sync_fifo #(
        .WIDTH ($bits(hf_entry_t)),
        .DEPTH (`HF_FIFO_DEPTH)
    ) u_hf_fifo (
        .ACLK   (ACLK),
        .ARESET (ARESET),
        .q      (hf_q)
    );

    async_dataframe_gen u_gen (
        .ACLK           (ACLK),
        .ARESET         (ARESET),
        .hf_q           (hf_q),
        .adc_q          (adc_q),
        .m_axis_tready  (m_axis_tready),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tkeep   (m_axis_tkeep),
        .m_axis_tlast   (m_axis_tlast),
        .underrun_error (underrun_error)
    );

endmodule

// File: async_dataframe_gen.sv
`include "dataframe_consts.svh"

module async_dataframe_gen (
    input  logic              ACLK,
    input  logic              ARESET,
    fifo_if.reader            hf_q,
    fifo_if.reader            adc_q,
    input  logic              m_axis_tready,
    output logic              m_axis_tvalid,
    output stream_pkg::beat_t m_axis_tdata,
    output stream_pkg::keep_t m_axis_tkeep,
    output logic              m_axis_tlast,
    output logic              underrun_error
);

    import stream_pkg::*;

    localparam int N_WORDS   = `HEADER_LINE + `FOOTER_LINE;
    localparam int HDR_BEATS = `HEADER_LINE / 2;
    localparam int FTR_BEATS = (`FOOTER_LINE + 1) / 2;
    // odd footer leaves the upper half of the last beat as padding
    localparam keep_t LAST_KEEP = (`FOOTER_LINE % 2 != 0) ?
                                  keep_t'({(`RFDC_TDATA_WIDTH/16){1'b1}}) : '1;

    gen_state_t            state;
    frame_pkg::frame_len_t cnt;        // beat index inside the current section
    frame_pkg::frame_len_t n_samples;  // from footer word 6
    frame_pkg::hf_entry_t  hf_r;
    frame_pkg::df_word_t   words [N_WORDS+1];
    beat_t                 next_data;
    keep_t                 next_keep;
    logic                  next_last;
    logic                  load_ok;
    logic                  adc_pop;
    logic                  load;

    for (genvar i = 0; i < N_WORDS; i++) begin : g_words
        assign words[i] = hf_r[(N_WORDS-1-i)*`DATAFRAME_WIDTH +: `DATAFRAME_WIDTH];
    end
    assign words[N_WORDS] = '1;

    assign n_samples = frame_pkg::frame_len_t'(words[N_WORDS-1]);

    assign load_ok = !m_axis_tvalid || m_axis_tready; // output reg free this cycle
    assign adc_pop = (state == SAMPLES) && load_ok && !adc_q.empty;
    assign load    = adc_pop || (load_ok && ((state == HEADER) || (state == FOOTER)));

    assign adc_q.rd_en = adc_pop;
    assign hf_q.rd_en  = (state == IDLE) && !hf_q.empty;

    always_ff @(posedge ACLK) begin
        if (hf_q.rd_en) begin
            hf_r <= hf_q.dout;
        end
    end

    // little endian with the earlier word in the low half
    always_comb begin
        next_data = adc_q.dout;
        next_keep = '1;
        next_last = 1'b0;
        case (state)
            HEADER: next_data = {words[2*cnt+1], words[2*cnt]};
            FOOTER: begin
                next_data = {words[`HEADER_LINE+2*cnt+1], words[`HEADER_LINE+2*cnt]};
                if (cnt == frame_pkg::frame_len_t'(FTR_BEATS - 1)) begin
                    next_keep = LAST_KEEP;
                    next_last = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state          <= IDLE;
            cnt            <= '0;
            underrun_error <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (!hf_q.empty) begin
                        cnt   <= '0;
                        state <= HEADER;
                    end
                end
                HEADER: begin
                    if (load_ok) begin
                        if (cnt == frame_pkg::frame_len_t'(HDR_BEATS - 1)) begin
                            cnt   <= '0;
                            state <= (n_samples == '0) ? FOOTER : SAMPLES;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                SAMPLES: begin
                    if (adc_pop) begin
                        if (cnt == n_samples - 1'b1) begin
                            cnt   <= '0;
                            state <= FOOTER;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: begin // FOOTER
                    if (load_ok) begin
                        if (cnt == frame_pkg::frame_len_t'(FTR_BEATS - 1)) begin
                            state <= IDLE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
            endcase
            if ((state == SAMPLES) && adc_q.empty) begin
                underrun_error <= 1'b1; // stalls here until samples show up
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end else if (load) begin
            m_axis_tvalid <= 1'b1;
            m_axis_tlast  <= next_last;
        end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (load) begin
            m_axis_tdata <= next_data;
            m_axis_tkeep <= next_keep;
        end
    end

endmodule

// File: frame_header_builder.sv
`include "dataframe_consts.svh"

module frame_header_builder (
    input  logic                  ACLK,
    input  logic                  ARESET,
    input  logic                  frame_start,
    input  frame_pkg::frame_len_t frame_len,
    input  frame_pkg::ch_id_t     ch_id,
    input  logic                  adc_valid,
    input  stream_pkg::beat_t     adc_data,
    fifo_if.writer                adc_q,
    fifo_if.writer                hf_q,
    output logic                  overflow_error,
    output logic                  busy
);

    import frame_pkg::*;

    localparam header_id_t HDR_ID = `HEADER_ID;
    localparam int PAD_W = `DATAFRAME_WIDTH - `HEADER_ID_WIDTH - `CH_ID_WIDTH
                           - `FRAME_LENGTH_WIDTH;

    capture_state_t state;
    frame_len_t     len_r;
    ch_id_t         ch_r;
    df_word_t       ts_r;
    df_word_t       ts_cnt;    // free-running timestamp
    df_word_t       seq_cnt;
    frame_len_t     beat_cnt;  // beats accepted this frame
    frame_len_t     wr_cnt;    // beats that actually went into adc_q
    df_word_t       xor_lo;
    df_word_t       xor_hi;
    df_word_t       word0;
    logic           accept;
    logic           last_beat;

    assign accept    = (state == CAPTURE) && adc_valid;
    assign last_beat = accept && (beat_cnt == len_r - 1'b1);
    assign busy      = (state != IDLE);

    assign adc_q.wr_en = accept && !adc_q.full;
    assign adc_q.din   = adc_data;

    assign word0 = {HDR_ID, ch_r, len_r, {PAD_W{1'b0}}};

    assign hf_q.wr_en = (state == WRITE_HF) && !hf_q.full;
    assign hf_q.din   = {word0, seq_cnt, ts_r, df_word_t'(`DF_MAGIC),
                         xor_lo, xor_hi, df_word_t'(wr_cnt)};

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state          <= IDLE;
            beat_cnt       <= '0;
            seq_cnt        <= '0;
            ts_cnt         <= '0;
            overflow_error <= 1'b0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (frame_start && (frame_len != '0)) begin
                        beat_cnt <= '0;
                        state    <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (accept) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        state <= WRITE_HF;
                    end
                end
                default: begin // WRITE_HF lasts one cycle
                    seq_cnt <= seq_cnt + 1'b1;
                    state   <= IDLE;
                end
            endcase
            // sticky on a lost beat or a lost HF entry
            if ((accept && adc_q.full) || ((state == WRITE_HF) && hf_q.full)) begin
                overflow_error <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if ((state == IDLE) && frame_start) begin
            len_r  <= frame_len;
            ch_r   <= ch_id;
            ts_r   <= ts_cnt;
            wr_cnt <= '0;
            xor_lo <= '0;
            xor_hi <= '0;
        end else if (adc_q.wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
            xor_lo <= xor_lo ^ adc_data[`DATAFRAME_WIDTH-1:0];
            xor_hi <= xor_hi ^ adc_data[`RFDC_TDATA_WIDTH-1 -: `DATAFRAME_WIDTH];
        end
    end

endmodule

// File: sync_fifo.sv
module sync_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 16
) (
    input logic ACLK,
    input logic ARESET,
    fifo_if.fifo q
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CW-1:0]    count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr = q.wr_en && !q.full;   // writes into a full FIFO are dropped
    assign do_rd = q.rd_en && !q.empty;

    assign q.full  = (count == CW'(DEPTH));
    assign q.empty = (count == '0);
    assign q.dout  = mem[rd_ptr];         // fall-through head

    always_ff @(posedge ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= q.din;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CW'(do_wr) - CW'(do_rd);
        end
    end

endmodule

// File: fifo_if.sv
interface fifo_if #(
    parameter int WIDTH = 64
);

    logic             wr_en;
    logic [WIDTH-1:0] din;
    logic             full;
    logic             rd_en;
    logic [WIDTH-1:0] dout;   // head entry while !empty
    logic             empty;

    modport writer (output wr_en, output din, input full);

    modport reader (output rd_en, input dout, input empty);

    modport fifo (
        input  wr_en,
        input  din,
        output full,
        input  rd_en,
        output dout,
        output empty
    );

endinterface

// File: stream_pkg.sv
`include "dataframe_consts.svh"

package stream_pkg;

    typedef logic [`RFDC_TDATA_WIDTH-1:0] beat_t;

    typedef logic [`RFDC_TDATA_WIDTH/8-1:0] keep_t; // one bit per byte

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        SAMPLES,
        FOOTER
    } gen_state_t;

endpackage

// File: frame_pkg.sv
`include "dataframe_consts.svh"

package frame_pkg;

    // frame length in ADC beats
    typedef logic [`FRAME_LENGTH_WIDTH-1:0] frame_len_t;

    typedef logic [`CH_ID_WIDTH-1:0] ch_id_t;

    typedef logic [`HEADER_ID_WIDTH-1:0] header_id_t;

    // one header or footer word
    typedef logic [`DATAFRAME_WIDTH-1:0] df_word_t;

    // word 0 sits in the top bits
    typedef logic [(`HEADER_LINE+`FOOTER_LINE)*`DATAFRAME_WIDTH-1:0] hf_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        WRITE_HF
    } capture_state_t;

endpackage

// File: dataframe_consts.svh
`ifndef DATAFRAME_CONSTS_SVH
`define DATAFRAME_CONSTS_SVH

// word and beat widths
`define DATAFRAME_WIDTH     32
`define RFDC_TDATA_WIDTH    64

// header and footer size in 32-bit words
`define HEADER_LINE         4
`define FOOTER_LINE         3

// fields of header word 0
`define FRAME_LENGTH_WIDTH  12
`define HEADER_ID_WIDTH     8
`define CH_ID_WIDTH         4
`define HEADER_ID           8'hA5

`define DF_MAGIC            32'hDA7A_F00D

// FIFO depths in entries
`define ADC_FIFO_DEPTH      64
`define HF_FIFO_DEPTH       4

`endif
